//--- logic/mdec_config.svh
`ifndef MDEC_CONFIG_SVH
`define MDEC_CONFIG_SVH

// Stream word that terminates a block
// Also used as padding between blocks
`define MDEC_END_OF_BLOCK 16'hFE00

// Blocks in one colour macroblock, Cr Cb Y0 Y1 Y2 Y3
`define MDEC_BLOCKS_PER_MB 6

// Fixed block number in monochrome mode, selects luma table
`define MDEC_MONO_BLOCK 2

// Effective scale for the DC term, cancels the final divide by 8
`define MDEC_DC_SCALE 8

// Effective scale for uncompressed full blocks, gives level x 2
`define MDEC_FULL_SCALE 16

// Rows of four packed 7-bit entries per quantization table
`define MDEC_QUANT_ROWS 16

`endif

//--- logic/mdecCoefPkg.sv
package mdecCoefPkg;

	// --------------------------------------------------
	// Coefficient arithmetic types
	// --------------------------------------------------

	// Signed level as found in bits 9:0 of a stream word
	typedef logic signed [9:0] coefIn_t;

	// Quantizer scale, bits 15:10 of a DC word
	typedef logic [5:0] scale_t;

	// One quantization table entry
	typedef logic [6:0] quant_t;

	// Four packed entries per table row
	// Entry k sits at bits 7k+6 down to 7k
	typedef logic [27:0] quantWord_t;

	// Level times effective scale
	// 10 bit x 6 bit fits easily in 16 bit
	typedef logic signed [15:0] scaled_t;

	// Saturated coefficient for IDCT storage, -2048..2047
	typedef logic signed [11:0] coefOut_t;

endpackage

//--- logic/mdecStreamPkg.sv
package mdecStreamPkg;

	// --------------------------------------------------
	// Stream and block addressing types
	// --------------------------------------------------

	// Raw compressed word, run or scale on top, level below
	typedef logic [15:0] rleWord_t;

	// Position inside an 8x8 block
	// Used for both zigzag and natural order
	typedef logic [5:0] coefIdx_t;

	// Block number within a macroblock, 0..5
	typedef logic [2:0] blockNum_t;

	// Run-length decoder FSM
	// WaitDc skips padding until a DC word shows up
	// InAc expands run/level pairs until the block ends
	typedef enum logic {
		WaitDc,
		InAc
	} rleState_t;

endpackage

//--- logic/coefLoadIf.sv
`timescale 1ns/1ns

interface coefLoadIf;

	// One-cycle strobe per coefficient, no acknowledge
	logic                        dataWrt;
	mdecCoefPkg::coefIn_t        dataIn;
	mdecCoefPkg::scale_t         scale;
	logic                        isDc;
	// Natural order, where the IDCT stores it
	mdecStreamPkg::coefIdx_t     index;
	// Zigzag order, quantization tables are kept this way
	mdecStreamPkg::coefIdx_t     zagIndex;
	logic                        fullBlockType;
	mdecStreamPkg::blockNum_t    blockNum;
	// Own cycle after the last load, dataWrt low
	logic                        matrixComplete;

	// Run-length side drives everything
	modport decoder (
		output dataWrt, dataIn, scale, isDc, index, zagIndex,
		output fullBlockType, blockNum, matrixComplete
	);

	// Dequantizer only listens
	modport dequant (
		input dataWrt, dataIn, scale, isDc, index, zagIndex,
		input fullBlockType, blockNum, matrixComplete
	);

endinterface

//--- logic/rleDecoder.sv
`timescale 1ns/1ns

`include "mdec_config.svh"

module rleDecoder (
	input  logic                       i_clk,
	input  logic                       i_arstN,
	input  logic                       i_dataValid,
	input  mdecStreamPkg::rleWord_t    i_data,
	input  logic                       i_fullBlockType,
	input  logic                       i_monochrome,
	coefLoadIf.decoder                 o_load
);

	// --------------------------------------------------
	// Zigzag position to natural index
	// --------------------------------------------------
	localparam mdecStreamPkg::coefIdx_t zigToNat [0:63] = '{
		 0,  1,  8, 16,  9,  2,  3, 10,
		17, 24, 32, 25, 18, 11,  4,  5,
		12, 19, 26, 33, 40, 48, 41, 34,
		27, 20, 13,  6,  7, 14, 21, 28,
		35, 42, 49, 56, 57, 50, 43, 36,
		29, 22, 15, 23, 30, 37, 44, 51,
		58, 59, 52, 45, 38, 31, 39, 46,
		53, 60, 61, 54, 47, 55, 62, 63
	};

	mdecStreamPkg::rleState_t   state;
	mdecStreamPkg::coefIdx_t    pos;
	mdecCoefPkg::scale_t        blockScale;
	mdecStreamPkg::blockNum_t   blkCnt;
	logic                       monoPrev;

	// --------------------------------------------------
	// Word decode
	// --------------------------------------------------
	logic                       isEob;
	mdecCoefPkg::scale_t        wordScale;
	logic [5:0]                 run;
	mdecCoefPkg::coefIn_t       level;
	// One extra bit to catch a run past 63
	logic [6:0]                 nextPos;
	mdecStreamPkg::coefIdx_t    loadPos;
	mdecStreamPkg::blockNum_t   curBlk;
	logic                       doDc;
	logic                       doAc;
	logic                       endBlk;

	assign isEob     = (i_data == `MDEC_END_OF_BLOCK);
	// Same bit field, scale on a DC word, run on an AC word
	assign wordScale = i_data[15:10];
	assign run       = i_data[15:10];
	assign level     = i_data[9:0];
	assign nextPos   = {1'b0, pos} + {1'b0, run} + 7'd1;

	// Padding in WaitDc falls through all three
	assign doDc   = i_dataValid && (state == mdecStreamPkg::WaitDc) && !isEob;
	assign doAc   = i_dataValid && (state == mdecStreamPkg::InAc) && !isEob && !nextPos[6];
	// EOB word or overflow; the overflowing word is dropped
	assign endBlk = i_dataValid && (state == mdecStreamPkg::InAc) && (isEob || nextPos[6]);

	assign loadPos = doDc ? 6'd0 : nextPos[5:0];
	assign curBlk  = i_monochrome ? mdecStreamPkg::blockNum_t'(`MDEC_MONO_BLOCK) : blkCnt;

	// --------------------------------------------------
	// FSM and block counter
	// --------------------------------------------------
	always_ff @(posedge i_clk or negedge i_arstN)
	begin
		if (!i_arstN)
		begin
			state                 <= mdecStreamPkg::WaitDc;
			pos                   <= '0;
			blkCnt                <= '0;
			monoPrev              <= 1'b0;
			o_load.dataWrt        <= 1'b0;
			o_load.matrixComplete <= 1'b0;
		end
		else
		begin
			o_load.dataWrt        <= doDc || doAc;
			o_load.matrixComplete <= endBlk;
			monoPrev              <= i_monochrome;

			if (doDc)
			begin
				state <= mdecStreamPkg::InAc;
				pos   <= '0;
			end
			// Position 63 alone keeps the block open
			if (doAc)
				pos <= nextPos[5:0];
			if (endBlk)
				state <= mdecStreamPkg::WaitDc;

			// Mode switch restarts the macroblock
			if (i_monochrome != monoPrev)
				blkCnt <= '0;
			else if (endBlk && !i_monochrome)
				blkCnt <= (blkCnt == 3'(`MDEC_BLOCKS_PER_MB - 1)) ? 3'd0 : blkCnt + 3'd1;
		end
	end

	// Load payload, qualified by dataWrt downstream
	always_ff @(posedge i_clk)
	begin
		if (doDc)
			blockScale <= wordScale;
		o_load.dataIn        <= level;
		// DC word carries the scale itself, AC reuses it
		o_load.scale         <= doDc ? wordScale : blockScale;
		o_load.isDc          <= doDc;
		o_load.index         <= zigToNat[loadPos];
		o_load.zagIndex      <= loadPos;
		o_load.fullBlockType <= i_fullBlockType;
		// Also tags the end pulse with the finishing block
		o_load.blockNum      <= curBlk;
	end

	// Load and end pulse never share a cycle
	loadCompleteExclusive: assert property (
		@(posedge i_clk) disable iff (!i_arstN)
		!(o_load.dataWrt && o_load.matrixComplete)
	);

endmodule

//--- logic/dequantizer.sv
`timescale 1ns/1ns

`include "mdec_config.svh"

module dequantizer (
	input  logic                        i_clk,
	input  logic                        i_arstN,
	coefLoadIf.dequant                  i_load,
	input  logic                        i_quantWrt,
	input  mdecCoefPkg::quantWord_t     i_quantValue,
	input  logic [3:0]                  i_quantAdr,
	input  logic                        i_quantTblSelect,
	output logic                        o_write,
	output mdecStreamPkg::coefIdx_t     o_writeIdx,
	output mdecStreamPkg::blockNum_t    o_blockNum,
	output mdecCoefPkg::coefOut_t       o_coefValue,
	output logic                        o_matrixComplete
);

	// --------------------------------------------------
	// Stage 0
	// --------------------------------------------------
	// Level x effective scale, issue table read

	mdecCoefPkg::scale_t      effScale;
	logic signed [6:0]        signedScale;
	mdecCoefPkg::scaled_t     multF;
	// Blocks 2..5 are luma, table 1
	logic                     selectTable;

	assign effScale    = i_load.fullBlockType ? mdecCoefPkg::scale_t'(`MDEC_FULL_SCALE)
	                   : i_load.isDc ? mdecCoefPkg::scale_t'(`MDEC_DC_SCALE)
	                   : i_load.scale;
	// Keep the scale positive in a signed multiply
	assign signedScale = {1'b0, effScale};
	assign multF       = mdecCoefPkg::scaled_t'(i_load.dataIn)
	                   * mdecCoefPkg::scaled_t'(signedScale);
	assign selectTable = i_load.blockNum[2] | i_load.blockNum[1];

	logic                       pWrite;
	logic                       pMatrixComplete;
	mdecStreamPkg::coefIdx_t    pIndex;
	mdecStreamPkg::blockNum_t   pBlk;
	logic                       pFullBlk;
	mdecCoefPkg::scaled_t       pMultF;

	always_ff @(posedge i_clk or negedge i_arstN)
	begin
		if (!i_arstN)
		begin
			pWrite          <= 1'b0;
			pMatrixComplete <= 1'b0;
		end
		else
		begin
			pWrite          <= i_load.dataWrt;
			pMatrixComplete <= i_load.matrixComplete;
		end
	end

	always_ff @(posedge i_clk)
	begin
		pIndex   <= i_load.index;
		pBlk     <= i_load.blockNum;
		pFullBlk <= i_load.fullBlockType;
		pMultF   <= multF;
	end

	// --------------------------------------------------
	// Quantization table RAM, two tables of 16 rows
	// --------------------------------------------------
	mdecCoefPkg::quantWord_t   quantTbl [0:2*`MDEC_QUANT_ROWS-1];
	logic [4:0]                quantRdAdr;
	logic [1:0]                pEntrySel;
	mdecCoefPkg::quantWord_t   quantRow;
	mdecCoefPkg::quant_t       quantEntry;

	always_ff @(posedge i_clk)
	begin
		if (i_quantWrt)
			quantTbl[{i_quantTblSelect, i_quantAdr}] <= i_quantValue;
		// Row from zigzag bits 5:2, entry from 1:0
		quantRdAdr <= {selectTable, i_load.zagIndex[5:2]};
		pEntrySel  <= i_load.zagIndex[1:0];
	end

	assign quantRow = quantTbl[quantRdAdr];

	always_comb
	begin
		case (pEntrySel)
			2'd0:    quantEntry = quantRow[6:0];
			2'd1:    quantEntry = quantRow[13:7];
			2'd2:    quantEntry = quantRow[20:14];
			default: quantEntry = quantRow[27:21];
		endcase
	end

	// --------------------------------------------------
	// Stage 1
	// --------------------------------------------------
	// x quant, /8 with floor, clamp to 12 bit

	logic signed [7:0]        quant;
	logic signed [23:0]       outCalc;
	logic signed [23:0]       shifted;
	mdecCoefPkg::coefOut_t    clipped;

	// Full block ignores the table
	assign quant   = pFullBlk ? 8'sd1 : $signed({1'b0, quantEntry});
	assign outCalc = 24'(pMultF) * 24'(quant);
	assign shifted = outCalc >>> 3;

	// Symmetric clamp, negative overflow pins to -2048
	always_comb
	begin
		if (shifted > 24'sd2047)
			clipped = 12'sd2047;
		else if (shifted < -24'sd2048)
			clipped = -12'sd2048;
		else
			clipped = shifted[11:0];
	end

	always_ff @(posedge i_clk or negedge i_arstN)
	begin
		if (!i_arstN)
		begin
			o_write          <= 1'b0;
			o_matrixComplete <= 1'b0;
		end
		else
		begin
			o_write          <= pWrite;
			o_matrixComplete <= pMatrixComplete;
		end
	end

	always_ff @(posedge i_clk)
	begin
		o_writeIdx  <= pIndex;
		o_blockNum  <= pBlk;
		o_coefValue <= clipped;
	end

	// Pulses stay exclusive through both stages
	writeCompleteExclusive: assert property (
		@(posedge i_clk) disable iff (!i_arstN)
		!(o_write && o_matrixComplete)
	);

endmodule

//--- logic/mdecFrontEnd.sv
`timescale 1ns/1ns

module mdecFrontEnd (
	input  logic                        i_clk,
	input  logic                        i_arstN,

	// Compressed stream, one word per cycle at most
	input  logic                        i_dataValid,
	input  mdecStreamPkg::rleWord_t     i_data,
	input  logic                        i_fullBlockType,
	input  logic                        i_monochrome,

	// Quantization table load port
	input  logic                        i_quantWrt,
	input  mdecCoefPkg::quantWord_t     i_quantValue,
	input  logic [3:0]                  i_quantAdr,
	input  logic                        i_quantTblSelect,

	// Coefficients toward IDCT storage, three cycles after the word
	output logic                        o_write,
	output mdecStreamPkg::coefIdx_t     o_writeIdx,
	output mdecStreamPkg::blockNum_t    o_blockNum,
	output mdecCoefPkg::coefOut_t       o_coefValue,
	output logic                        o_matrixComplete
);

	// Decoder to dequantizer load bus
	coefLoadIf loadBus ();

	// Stream parse, zigzag map, block count
	rleDecoder i_rleDecoder (
		.i_clk           (i_clk),
		.i_arstN         (i_arstN),
		.i_dataValid     (i_dataValid),
		.i_data          (i_data),
		.i_fullBlockType (i_fullBlockType),
		.i_monochrome    (i_monochrome),
		.o_load          (loadBus.decoder)
	);

	// Scale, quantize, saturate
	dequantizer i_dequantizer (
		.i_clk            (i_clk),
		.i_arstN          (i_arstN),
		.i_load           (loadBus.dequant),
		.i_quantWrt       (i_quantWrt),
		.i_quantValue     (i_quantValue),
		.i_quantAdr       (i_quantAdr),
		.i_quantTblSelect (i_quantTblSelect),
		.o_write          (o_write),
		.o_writeIdx       (o_writeIdx),
		.o_blockNum       (o_blockNum),
		.o_coefValue      (o_coefValue),
		.o_matrixComplete (o_matrixComplete)
	);

endmodule

//--- tests/mdecFrontEnd_tb.sv
`timescale 1ns/1ns

`include "mdec_config.svh"

module mdecFrontEnd_tb;

	logic                        i_clk;
	logic                        i_arstN;
	logic                        i_dataValid;
	mdecStreamPkg::rleWord_t     i_data;
	logic                        i_fullBlockType;
	logic                        i_monochrome;
	logic                        i_quantWrt;
	mdecCoefPkg::quantWord_t     i_quantValue;
	logic [3:0]                  i_quantAdr;
	logic                        i_quantTblSelect;
	logic                        o_write;
	mdecStreamPkg::coefIdx_t     o_writeIdx;
	mdecStreamPkg::blockNum_t    o_blockNum;
	mdecCoefPkg::coefOut_t       o_coefValue;
	logic                        o_matrixComplete;

	mdecFrontEnd i_dut (.*);

	always #5 i_clk = ~i_clk;

	// --------------------------------------------------
	// Reference model state
	// --------------------------------------------------
	mdecCoefPkg::quantWord_t     quantModel [0:2*`MDEC_QUANT_ROWS-1];
	mdecStreamPkg::coefIdx_t     natIdx [0:63];
	mdecCoefPkg::scale_t         modelScale;
	int                          modelPos;
	int                          modelBlk;
	logic                        inBlock;
	logic                        fullMode;
	logic                        monoMode;
	int                          cycle = 0;
	int                          errors = 0;
	int                          checks = 0;
	int                          tests = 0;
	int                          errBase = 0;

	// Expected writes and end pulses, oldest first
	mdecCoefPkg::coefOut_t       expCoefQ [$];
	mdecStreamPkg::coefIdx_t     expIdxQ [$];
	mdecStreamPkg::blockNum_t    expBlkQ [$];
	int                          expCycQ [$];
	mdecStreamPkg::blockNum_t    doneBlkQ [$];
	int                          doneCycQ [$];

	// Walk the 15 anti-diagonals of the 8x8 block
	task automatic buildZigzag();
		int n;
		int row;
		n = 0;
		for (int s = 0; s < 15; s++)
			for (int k = 0; k < 8; k++)
			begin
				// Even diagonals climb toward row 0, odd ones descend
				row = (s % 2 == 0) ? ((s < 8 ? s : 7) - k) : ((s < 8 ? 0 : s - 7) + k);
				if (row >= 0 && row < 8 && s - row >= 0 && s - row < 8)
				begin
					natIdx[n] = 6'(row * 8 + s - row);
					n++;
				end
			end
	endtask

	// Level x effective scale x effective quant, floor /8, clamp
	function automatic mdecCoefPkg::coefOut_t refCoef(mdecCoefPkg::coefIn_t level,
		mdecCoefPkg::scale_t scale, logic isDc, logic full, int zag, int blk);
		mdecCoefPkg::quantWord_t row;
		int effScale;
		int q;
		int value;
		row      = quantModel[(blk >= 2 ? 16 : 0) + zag / 4];
		effScale = full ? `MDEC_FULL_SCALE : (isDc ? `MDEC_DC_SCALE : int'(scale));
		q        = full ? 1 : int'(row[(zag % 4) * 7 +: 7]);
		value    = (int'(level) * effScale * q) >>> 3;
		if (value > 2047)
			value = 2047;
		else if (value < -2048)
			value = -2048;
		return mdecCoefPkg::coefOut_t'(value);
	endfunction

	function automatic int currentBlock();
		return monoMode ? `MDEC_MONO_BLOCK : modelBlk;
	endfunction

	function automatic mdecCoefPkg::coefIn_t randLevel();
		// Stay clear of -512, which with run 63 would spell an EOB word
		return mdecCoefPkg::coefIn_t'(int'($urandom_range(1022, 0)) - 511);
	endfunction

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic compareCoef(string name, mdecCoefPkg::coefOut_t got,
		mdecCoefPkg::coefOut_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compareIdx(string name, mdecStreamPkg::coefIdx_t got,
		mdecStreamPkg::coefIdx_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compareBlock(string name, mdecStreamPkg::blockNum_t got,
		mdecStreamPkg::blockNum_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compareFlag(string name, logic got, logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic checkLatency(string what, int due);
		checks++;
		if (due != cycle)
		begin
			errors++;
			$display("%s came at cycle %0d instead of cycle %0d", what, cycle, due);
		end
	endtask

	// Outputs move on the rising edge, so look at them on the falling one
	always @(negedge i_clk)
	begin
		if (o_write === 1'b1 && expCoefQ.size() == 0)
		begin
			errors++;
			$display("o_write pulsed at cycle %0d with nothing expected", cycle);
		end
		else if (o_write === 1'b1)
		begin
			checkLatency("coefficient write", expCycQ.pop_front());
			compareCoef("o_coefValue", o_coefValue, expCoefQ.pop_front());
			compareIdx("o_writeIdx", o_writeIdx, expIdxQ.pop_front());
			compareBlock("o_blockNum", o_blockNum, expBlkQ.pop_front());
		end
		if (o_matrixComplete === 1'b1 && doneBlkQ.size() == 0)
		begin
			errors++;
			$display("o_matrixComplete pulsed at cycle %0d with no block open", cycle);
		end
		else if (o_matrixComplete === 1'b1)
		begin
			checkLatency("end of block pulse", doneCycQ.pop_front());
			compareBlock("o_blockNum", o_blockNum, doneBlkQ.pop_front());
		end
	end

	always @(posedge i_clk)
		cycle <= cycle + 1;

	// --------------------------------------------------
	// Stimulus helpers, all entered on a falling edge
	// --------------------------------------------------
	task automatic driveWord(mdecStreamPkg::rleWord_t w);
		i_dataValid = 1'b1;
		i_data      = w;
		@(negedge i_clk);
		i_dataValid = 1'b0;
	endtask

	task automatic writeQuantRow(logic tbl, logic [3:0] row, mdecCoefPkg::quantWord_t w);
		i_quantWrt       = 1'b1;
		i_quantTblSelect = tbl;
		i_quantAdr       = row;
		i_quantValue     = w;
		quantModel[{tbl, row}] = w;
		@(negedge i_clk);
		i_quantWrt = 1'b0;
	endtask

	task automatic loadRandomTables();
		for (int t = 0; t < 2; t++)
			for (int r = 0; r < `MDEC_QUANT_ROWS; r++)
				writeQuantRow(t[0], r[3:0], mdecCoefPkg::quantWord_t'($urandom));
	endtask

	task automatic closeBlock();
		doneBlkQ.push_back(mdecStreamPkg::blockNum_t'(currentBlock()));
		doneCycQ.push_back(cycle + 3);
		inBlock = 1'b0;
		if (!monoMode)
			modelBlk = (modelBlk == `MDEC_BLOCKS_PER_MB - 1) ? 0 : modelBlk + 1;
	endtask

	task automatic expectWrite(mdecCoefPkg::coefIn_t lv, logic isDc, int pos);
		expCoefQ.push_back(refCoef(lv, modelScale, isDc, fullMode, pos, currentBlock()));
		expIdxQ.push_back(natIdx[pos]);
		expBlkQ.push_back(mdecStreamPkg::blockNum_t'(currentBlock()));
		expCycQ.push_back(cycle + 3);
	endtask

	task automatic sendDc(mdecCoefPkg::scale_t scale, mdecCoefPkg::coefIn_t lv);
		modelScale = scale;
		modelPos   = 0;
		inBlock    = 1'b1;
		expectWrite(lv, 1'b1, 0);
		driveWord({scale, lv});
	endtask

	// Position past 63 ends the block and the word is lost
	task automatic sendAc(int run, mdecCoefPkg::coefIn_t lv);
		if (modelPos + run + 1 > 63)
			closeBlock();
		else
		begin
			modelPos = modelPos + run + 1;
			expectWrite(lv, 1'b0, modelPos);
		end
		driveWord({6'(run), lv});
	endtask

	// Ends an open block, plain padding otherwise
	task automatic sendEob();
		if (inBlock)
			closeBlock();
		driveWord(`MDEC_END_OF_BLOCK);
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while ((expCoefQ.size() != 0 || doneBlkQ.size() != 0) && waited < 100)
		begin
			@(negedge i_clk);
			waited++;
		end
		if (expCoefQ.size() != 0)
		begin
			errors++;
			$display("Timeout: %0d coefficient writes never came on o_write", expCoefQ.size());
		end
		if (doneBlkQ.size() != 0)
		begin
			errors++;
			$display("Timeout: o_matrixComplete never came for %0d blocks", doneBlkQ.size());
		end
		expCoefQ.delete();
		expIdxQ.delete();
		expBlkQ.delete();
		expCycQ.delete();
		doneBlkQ.delete();
		doneCycQ.delete();
	endtask

	task automatic finishTest(string name);
		tests++;
		$display("%s finished with %0d errors", name, errors - errBase);
		errBase = errors;
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic resetHoldsOutputsLow();
		for (int i = 0; i < 20; i++)
		begin
			// Release after 16 cycles, then watch a few idle ones
			if (i == 16)
				i_arstN = 1'b1;
			@(negedge i_clk);
			compareFlag("o_write", o_write, 1'b0);
			compareFlag("o_matrixComplete", o_matrixComplete, 1'b0);
		end
		finishTest("reset state");
	endtask

	task automatic dequantizeColourBlock();
		int runs [10] = '{0, 0, 2, 0, 5, 1, 0, 3, 9, 0};
		loadRandomTables();
		// Words back to back, two loads in the pipeline at once
		sendDc(mdecCoefPkg::scale_t'($urandom_range(63, 1)), randLevel());
		foreach (runs[i])
			sendAc(runs[i], randLevel());
		sendEob();
		waitDrain();
		finishTest("standard dequantization");
	endtask

	task automatic fullBlockIgnoresTables();
		fullMode        = 1'b1;
		i_fullBlockType = 1'b1;
		sendDc(mdecCoefPkg::scale_t'($urandom_range(63, 1)), randLevel());
		for (int i = 0; i < 6; i++)
			sendAc(i % 3, randLevel());
		sendEob();
		waitDrain();
		fullMode        = 1'b0;
		i_fullBlockType = 1'b0;
		finishTest("full block mode");
	endtask

	task automatic saturateExtremes();
		// Block 2 reads table 1, first row at the maximum entry
		writeQuantRow(1'b1, 4'd0, {4{7'd127}});
		sendDc(6'd63, 10'sd511);
		sendAc(0, -10'sd511);
		// -8001 / 8 floors to -1001, truncation would give -1000
		sendAc(0, -10'sd1);
		sendAc(0, 10'sd1);
		sendEob();
		waitDrain();
		finishTest("saturation");
	endtask

	task automatic sequenceBlocks();
		// Blocks 3, 4, 5, then wrap to 0, 1, 2
		for (int b = 0; b < 6; b++)
		begin
			repeat (b % 3 + 1)
				sendEob();
			sendDc(mdecCoefPkg::scale_t'($urandom_range(63, 1)), randLevel());
			if (b == 0)
				sendAc(62, randLevel());
			else
				repeat (3)
					sendAc(int'($urandom_range(8, 0)), randLevel());
			if (b % 2 == 0)
				sendEob();
			else
				sendAc(63, 10'sd7);
		end
		waitDrain();
		finishTest("block sequencing");
	endtask

	task automatic holdMonoBlock();
		monoMode     = 1'b1;
		modelBlk     = 0;
		i_monochrome = 1'b1;
		@(negedge i_clk);
		repeat (3)
		begin
			sendDc(mdecCoefPkg::scale_t'($urandom_range(63, 1)), randLevel());
			sendAc(1, randLevel());
			sendAc(4, randLevel());
			sendEob();
		end
		waitDrain();
		finishTest("monochrome mode");
	endtask

	initial
	begin
		void'($urandom(32'h0a83_9908));
		i_clk            = 1'b0;
		i_arstN          = 1'b0;
		i_dataValid      = 1'b0;
		i_data           = '0;
		i_fullBlockType  = 1'b0;
		i_monochrome     = 1'b0;
		i_quantWrt       = 1'b0;
		i_quantValue     = '0;
		i_quantAdr       = '0;
		i_quantTblSelect = 1'b0;
		modelScale       = '0;
		modelPos         = 0;
		modelBlk         = 0;
		inBlock          = 1'b0;
		fullMode         = 1'b0;
		monoMode         = 1'b0;
		buildZigzag();
		resetHoldsOutputsLow();
		dequantizeColourBlock();
		fullBlockIgnoresTables();
		saturateExtremes();
		sequenceBlocks();
		holdMonoBlock();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+logic
logic/mdecCoefPkg.sv
logic/mdecStreamPkg.sv
logic/coefLoadIf.sv
logic/rleDecoder.sv
logic/dequantizer.sv
logic/mdecFrontEnd.sv
tests/mdecFrontEnd_tb.sv

//--- Bender.yml
package:
  name: mdec_front_end

sources:
  # RTL, packages before the modules that use them
  - include_dirs:
      - logic
    files:
      - logic/mdecCoefPkg.sv
      - logic/mdecStreamPkg.sv
      - logic/coefLoadIf.sv
      - logic/rleDecoder.sv
      - logic/dequantizer.sv
      - logic/mdecFrontEnd.sv

  # Directed testbench
  - target: test
    include_dirs:
      - logic
    files:
      - tests/mdecFrontEnd_tb.sv
